// File: pipeline_pkg.sv
`default_nettype none

package pipeline_pkg;

    typedef enum logic [4:0] {
        NOP, LD_B, LD_BU, LD_H, LD_HU, LD_W, ST_B, ST_H, ST_W, LL_W, SC_W,
        CSRRD, CSRWR, CSRXCHG, RDCNTID, RDCNTVL, RDCNTVH
    } mem_op_t;

    typedef enum logic [6:0] {
        NONE = 7'h00,
        ALE  = 7'h09  // LoongArch Ecode for misaligned address
    } exc_cause_t;

    localparam logic [13:0] CSR_CRMD  = 14'h000;
    localparam logic [13:0] CSR_ERA   = 14'h006;
    localparam logic [13:0] CSR_SAVE0 = 14'h030;
    localparam logic [13:0] CSR_TID   = 14'h040;

    localparam logic [31:0] TID_RESET = 32'h0000_0a11;  // Core ID seen by RDCNTID

    typedef struct packed {
        mem_op_t     op;
        logic [31:0] pc;
        logic [31:0] mem_addr;
        logic [31:0] store_data;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        logic [31:0] reg_write_data;
        logic [13:0] csr_addr;
        logic        csr_write_en;
        logic [31:0] csr_write_data;
        logic [31:0] csr_mask;
    } ex_mem_t;

    typedef struct packed {
        logic        write_en;
        logic [4:0]  write_addr;
        logic [31:0] write_data;
    } reg_write_t;

    typedef struct packed {
        logic        csr_write_en;
        logic [13:0] csr_write_addr;
        logic [31:0] csr_write_data;
        logic        llbit_write_en;
        logic        llbit_write_data;
    } csr_write_t;

    typedef struct packed {
        logic [31:0] pc;
        reg_write_t  reg_write;
        csr_write_t  csr_write;
        logic        is_exception;
        exc_cause_t  exc_cause;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    localparam int WB_ADDR_W  = 32;
    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);  // Word index width

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [3:0]           sel;
        logic [WB_ADDR_W-1:0] adr;
        logic [31:0]          dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic                 req;
        logic                 we;
        logic [3:0]           sel;
        logic [WB_ADDR_W-1:0] adr;
        logic [31:0]          dat;
    } bus_cmd_t;

endpackage

`default_nettype wire

// File: stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
        end else if (load) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_out <= data_in;
        end
    end

endmodule

`default_nettype wire

// File: stable_counter.sv
`timescale 1ns/10ps
`default_nettype none

module stable_counter (
    input  logic        clk,
    input  logic        arst_n,
    output logic [63:0] cnt
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= 64'd0;
        end else begin
            cnt <= cnt + 64'd1;  // Wraps after 2^64 cycles
        end
    end

endmodule

`default_nettype wire

// File: csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module csr_file (
    input  logic                     clk,
    input  logic                     arst_n,
    input  pipeline_pkg::csr_write_t wr,
    input  logic [13:0]              rd_addr,
    output logic [31:0]              rd_data,
    output logic                     llbit
);

    logic [31:0] crmd;
    logic [31:0] era;
    logic [31:0] save0;
    logic [31:0] tid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crmd  <= 32'd0;
            era   <= 32'd0;
            save0 <= 32'd0;
            tid   <= pipeline_pkg::TID_RESET;
            llbit <= 1'b0;
        end else begin
            if (wr.csr_write_en) begin
                case (wr.csr_write_addr)
                    pipeline_pkg::CSR_CRMD:  crmd  <= wr.csr_write_data;
                    pipeline_pkg::CSR_ERA:   era   <= wr.csr_write_data;
                    pipeline_pkg::CSR_SAVE0: save0 <= wr.csr_write_data;
                    pipeline_pkg::CSR_TID:   tid   <= wr.csr_write_data;
                    default: ;  // Unimplemented CSR, write dropped
                endcase
            end
            if (wr.llbit_write_en) begin
                llbit <= wr.llbit_write_data;
            end
        end
    end

    always_comb begin
        case (rd_addr)
            pipeline_pkg::CSR_CRMD:  rd_data = crmd;
            pipeline_pkg::CSR_ERA:   rd_data = era;
            pipeline_pkg::CSR_SAVE0: rd_data = save0;
            pipeline_pkg::CSR_TID:   rd_data = tid;
            default:                 rd_data = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: mem_access.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access (
    input  pipeline_pkg::ex_mem_t    instr,
    input  logic                     instr_valid,
    input  pipeline_pkg::csr_write_t wb_fwd,
    input  logic [31:0]              csr_rd_data,
    input  logic                     csr_llbit,
    input  logic [63:0]              cnt,
    input  logic                     bus_done,
    input  logic [31:0]              bus_rdata,
    output logic [13:0]              csr_rd_addr,
    output mem_bus_pkg::bus_cmd_t    bus_cmd,
    output pipeline_pkg::mem_wb_t    result
);

    logic [31:0] csr_old;
    logic        llbit;
    logic        half_op;
    logic        word_op;
    logic        mem_op;
    logic        ale;
    logic        bus_op;
    logic        commit;
    logic [31:0] lane;
    logic [31:0] rd_value;
    logic [31:0] csr_wd;
    logic        llbit_we;
    logic        llbit_wd;

    assign csr_rd_addr = (instr.op == pipeline_pkg::RDCNTID) ? pipeline_pkg::CSR_TID
                                                              : instr.csr_addr;

    // Writeback has not landed in the CSR file yet
    always_comb begin
        if (wb_fwd.csr_write_en && (wb_fwd.csr_write_addr == csr_rd_addr)) begin
            csr_old = wb_fwd.csr_write_data;
        end else begin
            csr_old = csr_rd_data;
        end
    end

    assign llbit = wb_fwd.llbit_write_en ? wb_fwd.llbit_write_data : csr_llbit;

    always_comb begin
        half_op = 1'b0;
        word_op = 1'b0;
        mem_op  = 1'b0;
        case (instr.op)
            pipeline_pkg::LD_B, pipeline_pkg::LD_BU, pipeline_pkg::ST_B: begin
                mem_op = 1'b1;
            end
            pipeline_pkg::LD_H, pipeline_pkg::LD_HU, pipeline_pkg::ST_H: begin
                half_op = 1'b1;
                mem_op  = 1'b1;
            end
            pipeline_pkg::LD_W, pipeline_pkg::ST_W, pipeline_pkg::LL_W: begin
                word_op = 1'b1;
                mem_op  = 1'b1;
            end
            pipeline_pkg::SC_W: begin
                word_op = 1'b1;  // Bus use depends on LL bit
            end
            default: ;
        endcase
    end

    assign ale    = (half_op & instr.mem_addr[0]) | (word_op & (|instr.mem_addr[1:0]));
    assign bus_op = mem_op | ((instr.op == pipeline_pkg::SC_W) & llbit);
    assign commit = instr_valid & ~ale & (~bus_op | bus_done);

    always_comb begin
        bus_cmd.req = instr_valid & bus_op & ~ale;
        bus_cmd.we  = 1'b0;
        bus_cmd.sel = 4'b1111;
        bus_cmd.adr = instr.mem_addr;
        bus_cmd.dat = instr.store_data;
        case (instr.op)
            pipeline_pkg::ST_B: begin
                bus_cmd.we  = 1'b1;
                bus_cmd.sel = 4'b0001 << instr.mem_addr[1:0];
                bus_cmd.dat = {4{instr.store_data[7:0]}};
            end
            pipeline_pkg::ST_H: begin
                bus_cmd.we  = 1'b1;
                bus_cmd.sel = 4'b0011 << instr.mem_addr[1:0];
                bus_cmd.dat = {2{instr.store_data[15:0]}};
            end
            pipeline_pkg::ST_W, pipeline_pkg::SC_W: begin
                bus_cmd.we = 1'b1;
            end
            default: ;
        endcase
    end

    assign lane = bus_rdata >> {instr.mem_addr[1:0], 3'b000};  // Addressed lane to bit 0

    always_comb begin
        rd_value = instr.reg_write_data;
        csr_wd   = instr.csr_write_data;
        llbit_we = 1'b0;
        llbit_wd = 1'b0;
        case (instr.op)
            pipeline_pkg::LD_B:  rd_value = {{24{lane[7]}}, lane[7:0]};
            pipeline_pkg::LD_BU: rd_value = {24'd0, lane[7:0]};
            pipeline_pkg::LD_H:  rd_value = {{16{lane[15]}}, lane[15:0]};
            pipeline_pkg::LD_HU: rd_value = {16'd0, lane[15:0]};
            pipeline_pkg::LD_W:  rd_value = bus_rdata;
            pipeline_pkg::LL_W: begin
                rd_value = bus_rdata;
                llbit_we = 1'b1;
                llbit_wd = 1'b1;
            end
            pipeline_pkg::SC_W: begin
                rd_value = {31'd0, llbit};
                llbit_we = llbit;  // Success clears the bit
            end
            pipeline_pkg::CSRRD, pipeline_pkg::CSRWR, pipeline_pkg::RDCNTID: begin
                rd_value = csr_old;
            end
            pipeline_pkg::CSRXCHG: begin
                rd_value = csr_old;
                csr_wd   = (csr_old & ~instr.csr_mask) | (instr.csr_write_data & instr.csr_mask);
            end
            pipeline_pkg::RDCNTVL: rd_value = cnt[31:0];
            pipeline_pkg::RDCNTVH: rd_value = cnt[63:32];
            default: ;
        endcase
    end

    assign result.pc                         = instr.pc;
    assign result.reg_write.write_en         = instr.reg_write_en & commit;
    assign result.reg_write.write_addr       = instr.reg_write_addr;
    assign result.reg_write.write_data       = rd_value;
    assign result.csr_write.csr_write_en     = instr.csr_write_en & commit;
    assign result.csr_write.csr_write_addr   = instr.csr_addr;
    assign result.csr_write.csr_write_data   = csr_wd;
    assign result.csr_write.llbit_write_en   = llbit_we & commit;
    assign result.csr_write.llbit_write_data = llbit_wd;
    assign result.is_exception               = ale;
    assign result.exc_cause = ale ? pipeline_pkg::ALE : pipeline_pkg::NONE;

endmodule

`default_nettype wire

// File: wb_bus_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module wb_bus_fsm (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mem_bus_pkg::bus_cmd_t cmd,
    input  mem_bus_pkg::wb_rsp_t  wb_rsp,
    output mem_bus_pkg::wb_req_t  wb_req,
    output logic                  done,
    output logic [31:0]           rdata,
    output logic                  stall
);

    typedef enum logic [1:0] {IDLE, CYCLE, DONE} state_t;

    state_t      state;
    state_t      state_nxt;
    logic [31:0] rdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // DONE is the cycle with cyc and stb dropped after ack
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE, DONE: state_nxt = cmd.req ? CYCLE : IDLE;
            CYCLE:      state_nxt = wb_rsp.ack ? DONE : CYCLE;
            default:    state_nxt = IDLE;
        endcase
    end

    assign wb_req.cyc = (state == CYCLE);
    assign wb_req.stb = (state == CYCLE);
    assign wb_req.we  = cmd.we;  // Command is held by the input register
    assign wb_req.sel = cmd.sel;
    assign wb_req.adr = cmd.adr;
    assign wb_req.dat = cmd.dat;

    assign done  = (state == CYCLE) & wb_rsp.ack;
    assign stall = cmd.req & ~done;

    always_ff @(posedge clk) begin
        if (done) begin
            rdata_q <= wb_rsp.dat;
        end
    end

    assign rdata = done ? wb_rsp.dat : rdata_q;

endmodule

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram (
    input  logic                 clk,
    input  logic                 arst_n,
    input  mem_bus_pkg::wb_req_t wb_req,
    output mem_bus_pkg::wb_rsp_t wb_rsp
);

    logic [31:0]                       mem [mem_bus_pkg::RAM_WORDS];
    logic [mem_bus_pkg::RAM_ADDR_W-1:0] idx;
    logic                              access;
    logic                              ack_q;
    logic [31:0]                       dat_q;

    assign idx    = wb_req.adr[mem_bus_pkg::RAM_ADDR_W+1:2];
    assign access = wb_req.cyc & wb_req.stb & ~ack_q;  // One ack per strobe

    initial begin
        for (int i = 0; i < mem_bus_pkg::RAM_WORDS; i++) begin
            mem[i] = 32'd0;
        end
    end

    always @(posedge clk) begin
        if (access) begin
            for (int b = 0; b < 4; b++) begin
                if (wb_req.we && wb_req.sel[b]) begin
                    mem[idx][8*b +: 8] <= wb_req.dat[8*b +: 8];
                end
            end
            dat_q <= mem[idx];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

endmodule

`default_nettype wire

// File: mem_stage_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  pipeline_pkg::ex_mem_t in_instr,
    output logic                  in_ready,
    output logic                  wb_valid,
    output pipeline_pkg::mem_wb_t wb_out
);

    logic                     cur_valid;
    pipeline_pkg::ex_mem_t    cur_instr;
    pipeline_pkg::mem_wb_t    result;
    mem_bus_pkg::bus_cmd_t    bus_cmd;
    mem_bus_pkg::wb_req_t     wb_req;
    mem_bus_pkg::wb_rsp_t     wb_rsp;
    logic                     bus_done;
    logic [31:0]              bus_rdata;
    logic                     stall;
    logic [13:0]              csr_rd_addr;
    logic [31:0]              csr_rd_data;
    logic                     llbit;
    logic [63:0]              cnt;

    assign in_ready = ~stall;

    stage_reg #(.payload_t(pipeline_pkg::ex_mem_t)) in_stage (
        .clk(clk), .arst_n(arst_n), .load(~stall), .valid_in(in_valid),
        .data_in(in_instr), .valid_out(cur_valid), .data_out(cur_instr)
    );

    mem_access access (
        .instr(cur_instr), .instr_valid(cur_valid), .wb_fwd(wb_out.csr_write),
        .csr_rd_data(csr_rd_data), .csr_llbit(llbit), .cnt(cnt), .bus_done(bus_done),
        .bus_rdata(bus_rdata), .csr_rd_addr(csr_rd_addr), .bus_cmd(bus_cmd), .result(result)
    );

    wb_bus_fsm bus_fsm (
        .clk(clk), .arst_n(arst_n), .cmd(bus_cmd), .wb_rsp(wb_rsp), .wb_req(wb_req),
        .done(bus_done), .rdata(bus_rdata), .stall(stall)
    );

    data_ram ram (.clk(clk), .arst_n(arst_n), .wb_req(wb_req), .wb_rsp(wb_rsp));

    // Bubble while stalled so a result is written back once
    stage_reg #(.payload_t(pipeline_pkg::mem_wb_t)) out_stage (
        .clk(clk), .arst_n(arst_n), .load(1'b1), .valid_in(cur_valid & ~stall),
        .data_in(result), .valid_out(wb_valid), .data_out(wb_out)
    );

    csr_file csrs (
        .clk(clk), .arst_n(arst_n), .wr(wb_out.csr_write), .rd_addr(csr_rd_addr),
        .rd_data(csr_rd_data), .llbit(llbit)
    );

    stable_counter counter (.clk(clk), .arst_n(arst_n), .cnt(cnt));

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD = 5;  // 10 ns period

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;  // Released clear of the edge
    end

endmodule

`default_nettype wire

// File: tb_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;

    typedef struct packed {
        pipeline_pkg::mem_op_t op;
        logic [31:0]           addr;
        logic [31:0]           sdata;
        logic [13:0]           csr_addr;
        logic [31:0]           csr_data;
        logic [31:0]           mask;
    } stim_t;

    typedef struct packed {
        logic [31:0]              pc;
        logic                     exc;
        pipeline_pkg::exc_cause_t cause;
        logic                     reg_we;
        logic [4:0]               reg_addr;
        logic [31:0]              reg_data;
        logic                     cnt_rising;  // RDCNTVL, compared with the previous one
        logic                     csr_we;
        logic [13:0]              csr_addr;
        logic [31:0]              csr_data;
        logic                     ll_we;
        logic                     ll_data;
    } expect_t;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    pipeline_pkg::ex_mem_t in_instr;
    logic                  in_ready;
    logic                  wb_valid;
    pipeline_pkg::mem_wb_t wb_out;

    stim_t       stim_q[$];
    expect_t     exp_q[$];
    logic [31:0] ref_mem [mem_bus_pkg::RAM_WORDS];
    logic [31:0] ref_csr [4];
    logic        ref_ll;
    logic [31:0] last_cnt;
    int          err_count;
    integer      seed;
    bit          table_built;

    tb_clock_gen clock0 (.clk(clk), .arst_n(arst_n));

    mem_stage_top dut0 (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_instr(in_instr),
        .in_ready(in_ready), .wb_valid(wb_valid), .wb_out(wb_out)
    );

    task automatic stop_with_error(input string line);
        err_count++;
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_field(input logic [31:0] got, input logic [31:0] exp_val,
                               input string name);
        assert (got === exp_val) else begin
            stop_with_error($sformatf("FAIL %0t: %s got %h expected %h",
                                      $time, name, got, exp_val));
        end
    endtask

    function automatic int csr_index(input logic [13:0] addr);
        case (addr)
            pipeline_pkg::CSR_CRMD:  return 0;
            pipeline_pkg::CSR_ERA:   return 1;
            pipeline_pkg::CSR_SAVE0: return 2;
            pipeline_pkg::CSR_TID:   return 3;
            default:                 return -1;
        endcase
    endfunction

    function automatic logic writes_reg(input pipeline_pkg::mem_op_t op);
        case (op)
            pipeline_pkg::NOP, pipeline_pkg::ST_B,
            pipeline_pkg::ST_H, pipeline_pkg::ST_W: return 1'b0;
            default:                                return 1'b1;
        endcase
    endfunction

    task automatic add_mem(input pipeline_pkg::mem_op_t op, input logic [31:0] addr,
                           input logic [31:0] sdata);
        stim_t s;
        s       = '0;
        s.op    = op;
        s.addr  = addr;
        s.sdata = sdata;
        stim_q.push_back(s);
    endtask

    task automatic add_csr(input pipeline_pkg::mem_op_t op, input logic [13:0] csr_addr,
                           input logic [31:0] csr_data, input logic [31:0] mask);
        stim_t s;
        s          = '0;
        s.op       = op;
        s.csr_addr = csr_addr;
        s.csr_data = csr_data;
        s.mask     = mask;
        stim_q.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] base;
        seed = 32'h3ddb;
        add_csr(pipeline_pkg::RDCNTID, 14'h0, 32'h0, 32'h0);  // Latency probe
        add_mem(pipeline_pkg::ST_W, 32'h100, 32'hf1e2_d3c4);
        add_mem(pipeline_pkg::ST_W, 32'h104, 32'h1234_5678);
        add_mem(pipeline_pkg::ST_H, 32'h106, 32'h0000_9abc);
        add_mem(pipeline_pkg::ST_B, 32'h101, 32'h0000_007f);
        add_mem(pipeline_pkg::ST_B, 32'h10b, 32'h0000_0080);
        add_mem(pipeline_pkg::ST_W, 32'h10c, $random(seed));
        for (int w = 0; w < 2; w++) begin
            base = 32'h100 + 4 * w;
            for (int b = 0; b < 4; b++) begin
                add_mem(pipeline_pkg::LD_B, base + b, 32'h0);
                add_mem(pipeline_pkg::LD_BU, base + b, 32'h0);
            end
            for (int h = 0; h < 4; h += 2) begin
                add_mem(pipeline_pkg::LD_H, base + h, 32'h0);
                add_mem(pipeline_pkg::LD_HU, base + h, 32'h0);
            end
            add_mem(pipeline_pkg::LD_W, base, 32'h0);
        end
        add_mem(pipeline_pkg::LD_W, 32'h108, 32'h0);
        add_mem(pipeline_pkg::LD_W, 32'h10c, 32'h0);
        // Misaligned, none of these may touch memory
        add_mem(pipeline_pkg::LD_H, 32'h101, 32'h0);
        add_mem(pipeline_pkg::LD_HU, 32'h103, 32'h0);
        add_mem(pipeline_pkg::LD_W, 32'h102, 32'h0);
        add_mem(pipeline_pkg::ST_H, 32'h103, 32'hffff_ffff);
        add_mem(pipeline_pkg::ST_W, 32'h101, 32'hffff_ffff);
        add_mem(pipeline_pkg::LL_W, 32'h106, 32'h0);
        add_mem(pipeline_pkg::SC_W, 32'h105, 32'hffff_ffff);
        add_mem(pipeline_pkg::LD_W, 32'h100, 32'h0);
        add_mem(pipeline_pkg::LD_W, 32'h104, 32'h0);
        add_mem(pipeline_pkg::SC_W, 32'h110, 32'haaaa_5555);  // No reservation yet
        add_mem(pipeline_pkg::LD_W, 32'h110, 32'h0);
        add_mem(pipeline_pkg::LL_W, 32'h110, 32'h0);
        add_mem(pipeline_pkg::SC_W, 32'h110, 32'h1357_9bdf);
        add_mem(pipeline_pkg::SC_W, 32'h110, 32'hdead_beef);
        add_mem(pipeline_pkg::LD_W, 32'h110, 32'h0);
        add_csr(pipeline_pkg::CSRWR, pipeline_pkg::CSR_SAVE0, 32'h1111_2222, 32'h0);
        add_csr(pipeline_pkg::CSRRD, pipeline_pkg::CSR_SAVE0, 32'h0, 32'h0);
        add_csr(pipeline_pkg::CSRXCHG, pipeline_pkg::CSR_SAVE0, 32'habcd_ef00, 32'h0000_ffff);
        add_csr(pipeline_pkg::CSRRD, pipeline_pkg::CSR_SAVE0, 32'h0, 32'h0);
        add_csr(pipeline_pkg::CSRWR, pipeline_pkg::CSR_SAVE0, 32'h5a5a_5a5a, 32'h0);
        add_csr(pipeline_pkg::CSRXCHG, pipeline_pkg::CSR_ERA, 32'hffff_ffff, 32'h0f0f_0f0f);
        add_csr(pipeline_pkg::CSRRD, pipeline_pkg::CSR_ERA, 32'h0, 32'h0);
        add_csr(pipeline_pkg::CSRWR, pipeline_pkg::CSR_CRMD, 32'h0000_0008, 32'h0);
        add_csr(pipeline_pkg::CSRXCHG, pipeline_pkg::CSR_CRMD, 32'h0000_0003, 32'h0000_0007);
        add_csr(pipeline_pkg::CSRRD, pipeline_pkg::CSR_CRMD, 32'h0, 32'h0);
        add_csr(pipeline_pkg::CSRRD, 14'h7ff, 32'h0, 32'h0);  // Unimplemented, reads 0
        add_csr(pipeline_pkg::RDCNTID, 14'h0, 32'h0, 32'h0);
        add_csr(pipeline_pkg::RDCNTVL, 14'h0, 32'h0, 32'h0);
        add_csr(pipeline_pkg::RDCNTVH, 14'h0, 32'h0, 32'h0);
        add_csr(pipeline_pkg::RDCNTVL, 14'h0, 32'h0, 32'h0);
        add_csr(pipeline_pkg::RDCNTVL, 14'h0, 32'h0, 32'h0);
        add_csr(pipeline_pkg::RDCNTVH, 14'h0, 32'h0, 32'h0);
        add_csr(pipeline_pkg::RDCNTVL, 14'h0, 32'h0, 32'h0);
    endtask

    // Architectural model, applied in program order
    task automatic predict(input stim_t s, input int idx, output expect_t e);
        int          wi;
        int          ci;
        logic [13:0] rd_addr;
        logic [31:0] word;
        logic [31:0] old;
        logic [7:0]  lane_b;
        logic [15:0] lane_h;
        logic        half;
        logic        full;
        wi      = s.addr[mem_bus_pkg::RAM_ADDR_W+1:2];
        rd_addr = (s.op == pipeline_pkg::RDCNTID) ? pipeline_pkg::CSR_TID : s.csr_addr;
        ci      = csr_index(rd_addr);
        old     = (ci >= 0) ? ref_csr[ci] : 32'd0;
        word    = ref_mem[wi];
        lane_b  = word[8 * s.addr[1:0] +: 8];
        lane_h  = word[16 * s.addr[1] +: 16];
        half    = 1'b0;
        full    = 1'b0;
        case (s.op)
            pipeline_pkg::LD_H, pipeline_pkg::LD_HU, pipeline_pkg::ST_H: half = 1'b1;
            pipeline_pkg::LD_W, pipeline_pkg::ST_W,
            pipeline_pkg::LL_W, pipeline_pkg::SC_W: full = 1'b1;
            default: ;
        endcase
        e          = '0;
        e.pc       = 32'h1c00_0000 + 4 * idx;
        e.reg_addr = idx[4:0];
        e.cause    = pipeline_pkg::NONE;
        if ((half && s.addr[0]) || (full && (s.addr[1:0] != 2'b00))) begin
            e.exc   = 1'b1;
            e.cause = pipeline_pkg::ALE;
        end else begin
            e.reg_we = writes_reg(s.op);
            case (s.op)
                pipeline_pkg::LD_B:  e.reg_data = {{24{lane_b[7]}}, lane_b};
                pipeline_pkg::LD_BU: e.reg_data = {24'd0, lane_b};
                pipeline_pkg::LD_H:  e.reg_data = {{16{lane_h[15]}}, lane_h};
                pipeline_pkg::LD_HU: e.reg_data = {16'd0, lane_h};
                pipeline_pkg::LD_W:  e.reg_data = word;
                pipeline_pkg::ST_B:  ref_mem[wi][8 * s.addr[1:0] +: 8] = s.sdata[7:0];
                pipeline_pkg::ST_H:  ref_mem[wi][16 * s.addr[1] +: 16] = s.sdata[15:0];
                pipeline_pkg::ST_W:  ref_mem[wi] = s.sdata;
                pipeline_pkg::LL_W: begin
                    e.reg_data = word;
                    e.ll_we    = 1'b1;
                    e.ll_data  = 1'b1;
                    ref_ll     = 1'b1;
                end
                pipeline_pkg::SC_W: begin
                    e.reg_data = {31'd0, ref_ll};
                    e.ll_we    = ref_ll;
                    if (ref_ll) begin
                        ref_mem[wi] = s.sdata;
                    end
                    ref_ll = 1'b0;
                end
                pipeline_pkg::CSRRD, pipeline_pkg::RDCNTID: e.reg_data = old;
                pipeline_pkg::CSRWR, pipeline_pkg::CSRXCHG: begin
                    e.reg_data = old;
                    e.csr_we   = 1'b1;
                    e.csr_addr = s.csr_addr;
                    e.csr_data = (s.op == pipeline_pkg::CSRWR) ? s.csr_data
                               : ((old & ~s.mask) | (s.csr_data & s.mask));
                    if (ci >= 0) begin
                        ref_csr[ci] = e.csr_data;
                    end
                end
                pipeline_pkg::RDCNTVL: e.cnt_rising = 1'b1;
                pipeline_pkg::RDCNTVH: e.reg_data = 32'd0;  // High word stays 0 in a short run
                default: ;
            endcase
        end
    endtask

    task automatic issue_entry(input int idx);
        stim_t   s;
        expect_t e;
        s = stim_q[idx];
        predict(s, idx, e);
        exp_q.push_back(e);
        in_instr                = '0;
        in_instr.op             = s.op;
        in_instr.pc             = e.pc;
        in_instr.mem_addr       = s.addr;
        in_instr.store_data     = s.sdata;
        in_instr.reg_write_en   = writes_reg(s.op);
        in_instr.reg_write_addr = e.reg_addr;
        in_instr.csr_addr       = s.csr_addr;
        in_instr.csr_write_en   = (s.op == pipeline_pkg::CSRWR) || (s.op == pipeline_pkg::CSRXCHG);
        in_instr.csr_write_data = s.csr_data;
        in_instr.csr_mask       = s.mask;
        in_valid                = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);  // Accepted here
        #1;
        in_valid = 1'b0;
    endtask

    task automatic check_result();
        expect_t e;
        assert (exp_q.size() != 0) else begin
            stop_with_error("A result was written back while no instruction was outstanding");
        end
        e = exp_q.pop_front();
        check_field(wb_out.pc, e.pc, "pc");
        check_field(wb_out.is_exception, e.exc, "is_exception");
        check_field(wb_out.exc_cause, e.cause, "exc_cause");
        check_field(wb_out.reg_write.write_en, e.reg_we, "reg write_en");
        if (e.reg_we) begin
            check_field(wb_out.reg_write.write_addr, e.reg_addr, "reg write_addr");
            if (e.cnt_rising) begin
                assert (wb_out.reg_write.write_data > last_cnt) else begin
                    stop_with_error($sformatf("FAIL %0t: RDCNTVL %h is not above %h", $time,
                                              wb_out.reg_write.write_data, last_cnt));
                end
                last_cnt = wb_out.reg_write.write_data;
            end else begin
                check_field(wb_out.reg_write.write_data, e.reg_data, "reg write_data");
            end
        end
        check_field(wb_out.csr_write.csr_write_en, e.csr_we, "csr_write_en");
        if (e.csr_we) begin
            check_field(wb_out.csr_write.csr_write_addr, e.csr_addr, "csr_write_addr");
            check_field(wb_out.csr_write.csr_write_data, e.csr_data, "csr_write_data");
        end
        check_field(wb_out.csr_write.llbit_write_en, e.ll_we, "llbit_write_en");
        if (e.ll_we) begin
            check_field(wb_out.csr_write.llbit_write_data, e.ll_data, "llbit_write_data");
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            check_result();
        end
    end

    initial begin
        wait (table_built);
        #((stim_q.size() * 10 + 20) * 10);
        $display("Timeout: the test did not complete within %0d cycles",
                 stim_q.size() * 10 + 20);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        in_valid  = 1'b0;
        in_instr  = '0;
        err_count = 0;
        last_cnt  = 32'd0;
        ref_ll    = 1'b0;
        for (int i = 0; i < mem_bus_pkg::RAM_WORDS; i++) begin
            ref_mem[i] = 32'd0;
        end
        for (int i = 0; i < 3; i++) begin
            ref_csr[i] = 32'd0;
        end
        ref_csr[3] = pipeline_pkg::TID_RESET;
        build_table();
        table_built = 1'b1;
        @(negedge clk);
        check_field(wb_valid, 1'b0, "wb_valid during reset");
        check_field(in_ready, 1'b1, "in_ready during reset");
        wait (arst_n === 1'b1);
        @(negedge clk);
        check_field(wb_valid, 1'b0, "wb_valid after reset");
        check_field(in_ready, 1'b1, "in_ready after reset");
        @(posedge clk);
        #1;
        for (int i = 0; i < stim_q.size(); i++) begin
            issue_entry(i);
            if (i == 0) begin
                check_field(wb_valid, 1'b0, "wb_valid at the accepting edge");
                @(negedge clk);
                check_field(wb_valid, 1'b0, "wb_valid before the next edge");
                @(posedge clk);
                #1;
                check_field(wb_valid, 1'b1, "wb_valid two edges after acceptance");
            end
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);  // Catch any stray result
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
pipeline_pkg.sv
mem_bus_pkg.sv
stage_reg.sv
stable_counter.sv
csr_file.sv
mem_access.sv
wb_bus_fsm.sv
data_ram.sv
mem_stage_top.sv
tb_clock_gen.sv
tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - pipeline_pkg.sv
  - mem_bus_pkg.sv
  - stage_reg.sv
  - stable_counter.sv
  - csr_file.sv
  - mem_access.sv
  - wb_bus_fsm.sv
  - data_ram.sv
  - mem_stage_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_mem_stage.sv
